// File: include/eth_settings.svh
/* Build-time settings for the MII receive MAC.
   Included by the FCS checker and the frame FIFO, and by the testbench. */
`ifndef ETH_SETTINGS_SVH
`define ETH_SETTINGS_SVH

// Frame FIFO holds 2**ETH_RX_FIFO_ADDR_W bytes
`define ETH_RX_FIFO_ADDR_W 8

// Shortest legal frame, FCS included
`define ETH_MIN_FRAME_BYTES 64

// Reflected CRC-32 register value after a frame with a correct FCS
`define ETH_FCS_RESIDUE 32'hdebb20e3

`endif

// File: rtl/eth_fcs_check.sv
/* FCS checker. Runs CRC-32 over every byte, holds back the last four bytes
   so the FCS is never forwarded, and grades the frame at frame_end. */
`timescale 1ns/1ps

`include "eth_settings.svh"

module eth_fcs_check (
    input  logic                      logic_clk,
    input  logic                      logic_rst,
    input  logic                      byte_valid,
    input  eth_stream_pkg::eth_byte_t byte_data,
    input  logic                      frame_end,
    input  logic                      frame_err,
    output logic                      out_valid,
    output eth_stream_pkg::eth_byte_t out_data,
    output logic                      out_end,
    output logic                      out_good,
    output logic                      rx_error_bad_frame,
    output logic                      rx_error_bad_fcs
);
    import eth_stream_pkg::*;

    localparam eth_crc_t CRC_POLY = 32'hedb88320;
    localparam eth_crc_t CRC_INIT = 32'hffffffff;

    eth_crc_t    crc_reg;
    logic [15:0] byte_count;
    logic [2:0]  fill;
    eth_byte_t   delay_line [4];
    logic        fcs_ok;
    logic        len_ok;

    // Bitwise update, LSB first
    function automatic eth_crc_t crc_step(eth_crc_t crc, eth_byte_t data);
        eth_crc_t c;
        int       i;
        c = crc;
        for (i = 0; i < 8; i++) begin
            c = (c >> 1) ^ (CRC_POLY & {32{c[0] ^ data[i]}});
        end
        return c;
    endfunction

    assign fcs_ok = (crc_reg == `ETH_FCS_RESIDUE);
    assign len_ok = (byte_count >= 16'(`ETH_MIN_FRAME_BYTES));

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            crc_reg            <= CRC_INIT;
            byte_count         <= '0;
            fill               <= '0;
            out_valid          <= 1'b0;
            out_end            <= 1'b0;
            out_good           <= 1'b0;
            rx_error_bad_frame <= 1'b0;
            rx_error_bad_fcs   <= 1'b0;
        end else begin
            out_valid          <= 1'b0;
            out_end            <= 1'b0;
            rx_error_bad_frame <= 1'b0;
            rx_error_bad_fcs   <= 1'b0;
            if (frame_end) begin
                crc_reg            <= CRC_INIT;
                byte_count         <= '0;
                fill               <= '0;
                out_end            <= 1'b1;
                out_good           <= fcs_ok && len_ok && !frame_err;
                rx_error_bad_frame <= frame_err;
                // Errored frames report only the line error
                rx_error_bad_fcs   <= !frame_err && !fcs_ok;
            end else if (byte_valid) begin
                crc_reg <= crc_step(crc_reg, byte_data);
                if (~&byte_count) begin
                    byte_count <= byte_count + 1'b1;
                end
                if (fill == 3'd4) begin
                    out_valid <= 1'b1;
                end else begin
                    fill <= fill + 1'b1;
                end
            end
        end
    end

    // Four-byte hold-back line
    always_ff @(posedge logic_clk) begin
        if (byte_valid) begin
            delay_line[0] <= byte_data;
            delay_line[1] <= delay_line[0];
            delay_line[2] <= delay_line[1];
            delay_line[3] <= delay_line[2];
            out_data      <= delay_line[3];
        end
    end

endmodule

// File: rtl/eth_mac_mii_rx.sv
/* Receive MAC for 10/100 MII. MII nibbles in, good frames out as a byte
   stream with valid/ready, plus one-cycle status pulses per frame. */
`timescale 1ns/1ps

module eth_mac_mii_rx (
    input  logic                      logic_clk,
    input  logic                      logic_rst,
    input  mii_pkg::mii_nibble_t      mii_rxd,
    input  logic                      mii_rx_dv,
    input  logic                      mii_rx_er,
    output eth_stream_pkg::eth_byte_t rx_axis_tdata,
    output logic                      rx_axis_tvalid,
    input  logic                      rx_axis_tready,
    output logic                      rx_axis_tlast,
    output logic                      rx_error_bad_frame,
    output logic                      rx_error_bad_fcs,
    output logic                      rx_fifo_overflow,
    output logic                      rx_fifo_good_frame,
    output logic                      rx_fifo_bad_frame
);
    import eth_stream_pkg::*;

    // Decoder to FCS checker
    logic      byte_valid;
    eth_byte_t byte_data;
    logic      frame_end;
    logic      frame_err;

    // FCS checker to FIFO
    logic      out_valid;
    eth_byte_t out_data;
    logic      out_end;
    logic      out_good;

    mii_rx_decode mii_rx_decode_i (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .mii_rxd    (mii_rxd),
        .mii_rx_dv  (mii_rx_dv),
        .mii_rx_er  (mii_rx_er),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .frame_end  (frame_end),
        .frame_err  (frame_err)
    );

    eth_fcs_check eth_fcs_check_i (
        .logic_clk          (logic_clk),
        .logic_rst          (logic_rst),
        .byte_valid         (byte_valid),
        .byte_data          (byte_data),
        .frame_end          (frame_end),
        .frame_err          (frame_err),
        .out_valid          (out_valid),
        .out_data           (out_data),
        .out_end            (out_end),
        .out_good           (out_good),
        .rx_error_bad_frame (rx_error_bad_frame),
        .rx_error_bad_fcs   (rx_error_bad_fcs)
    );

    rx_frame_fifo rx_frame_fifo_i (
        .logic_clk          (logic_clk),
        .logic_rst          (logic_rst),
        .out_valid          (out_valid),
        .out_data           (out_data),
        .out_end            (out_end),
        .out_good           (out_good),
        .rx_axis_tdata      (rx_axis_tdata),
        .rx_axis_tvalid     (rx_axis_tvalid),
        .rx_axis_tready     (rx_axis_tready),
        .rx_axis_tlast      (rx_axis_tlast),
        .rx_fifo_overflow   (rx_fifo_overflow),
        .rx_fifo_good_frame (rx_fifo_good_frame),
        .rx_fifo_bad_frame  (rx_fifo_bad_frame)
    );

endmodule

// File: rtl/eth_stream_pkg.sv
/* Types for the receive byte stream, the CRC-32 check and the frame FIFO. */
package eth_stream_pkg;

    // One frame byte
    typedef logic [7:0] eth_byte_t;

    // CRC-32 register, reflected form
    typedef logic [31:0] eth_crc_t;

    // FIFO entry, last flag in bit 8 above the byte
    typedef logic [8:0] fifo_word_t;

endpackage

// File: rtl/mii_pkg.sv
/* Types for the MII line side of the receive MAC. */
package mii_pkg;

    // One MII data nibble
    typedef logic [3:0] mii_nibble_t;

    // Receive decoder FSM
    typedef enum logic [1:0] {
        IDLE,
        PREAMBLE,
        DATA,
        DROP
    } mii_rx_state_t;

endpackage

// File: rtl/mii_rx_decode.sv
/* MII receive decoder. Waits for preamble and SFD, then pairs nibbles into
   bytes, low nibble first. Gives frame_end with frame_err when rx_dv falls. */
`timescale 1ns/1ps

module mii_rx_decode (
    input  logic                      logic_clk,
    input  logic                      logic_rst,
    input  mii_pkg::mii_nibble_t      mii_rxd,
    input  logic                      mii_rx_dv,
    input  logic                      mii_rx_er,
    output logic                      byte_valid,
    output eth_stream_pkg::eth_byte_t byte_data,
    output logic                      frame_end,
    output logic                      frame_err
);
    import mii_pkg::*;
    import eth_stream_pkg::*;

    localparam mii_nibble_t NIB_PRE = 4'h5;
    localparam mii_nibble_t NIB_SFD = 4'hd;

    mii_rx_state_t state;
    mii_nibble_t   low_nibble;
    logic          high_phase;
    logic          err_seen;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state      <= IDLE;
            high_phase <= 1'b0;
            err_seen   <= 1'b0;
            byte_valid <= 1'b0;
            frame_end  <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            frame_end  <= 1'b0;
            case (state)
                IDLE: begin
                    if (mii_rx_dv) begin
                        state <= (mii_rxd == NIB_PRE && !mii_rx_er) ? PREAMBLE : DROP;
                    end
                end
                PREAMBLE: begin
                    high_phase <= 1'b0;
                    err_seen   <= 1'b0;
                    // Lost carrier inside the preamble, nothing to report
                    if (!mii_rx_dv) begin
                        state <= IDLE;
                    end else if (mii_rx_er) begin
                        state <= DROP;
                    end else if (mii_rxd == NIB_SFD) begin
                        state <= DATA;
                    end else if (mii_rxd != NIB_PRE) begin
                        state <= DROP;
                    end
                end
                DATA: begin
                    if (mii_rx_dv) begin
                        err_seen   <= err_seen | mii_rx_er;
                        high_phase <= !high_phase;
                        byte_valid <= high_phase;
                    end else begin
                        // A dangling low nibble means an odd nibble count
                        frame_end <= 1'b1;
                        frame_err <= err_seen | high_phase;
                        state     <= IDLE;
                    end
                end
                DROP: begin
                    if (!mii_rx_dv) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Nibble pairing
    always_ff @(posedge logic_clk) begin
        if (state == DATA && mii_rx_dv) begin
            if (high_phase) begin
                byte_data <= eth_byte_t'({mii_rxd, low_nibble});
            end else begin
                low_nibble <= mii_rxd;
            end
        end
    end

endmodule

// File: rtl/rx_frame_fifo.sv
/* Receive frame FIFO. Bytes are written speculatively and committed at
   out_end only for a good frame that fit; anything else is rolled back. */
`timescale 1ns/1ps

`include "eth_settings.svh"

module rx_frame_fifo #(
    parameter int ADDR_WIDTH = `ETH_RX_FIFO_ADDR_W
) (
    input  logic                      logic_clk,
    input  logic                      logic_rst,
    input  logic                      out_valid,
    input  eth_stream_pkg::eth_byte_t out_data,
    input  logic                      out_end,
    input  logic                      out_good,
    output eth_stream_pkg::eth_byte_t rx_axis_tdata,
    output logic                      rx_axis_tvalid,
    input  logic                      rx_axis_tready,
    output logic                      rx_axis_tlast,
    output logic                      rx_fifo_overflow,
    output logic                      rx_fifo_good_frame,
    output logic                      rx_fifo_bad_frame
);
    import eth_stream_pkg::*;

    localparam int DEPTH = 1 << ADDR_WIDTH;

    fifo_word_t            mem [DEPTH];
    logic [ADDR_WIDTH:0]   wr_ptr;
    logic [ADDR_WIDTH:0]   commit_ptr;
    logic [ADDR_WIDTH:0]   rd_ptr;
    logic [ADDR_WIDTH:0]   last_ptr;
    logic [ADDR_WIDTH-1:0] mem_waddr;
    fifo_word_t            mem_wdata;
    fifo_word_t            rd_word;
    eth_byte_t             last_byte;
    logic                  full;
    logic                  drop_frame;
    logic                  has_data;
    logic                  commit;
    logic                  mem_we;
    logic                  load_out;

    // Full is measured against the read side, so speculative bytes count too
    assign full     = (wr_ptr == {~rd_ptr[ADDR_WIDTH], rd_ptr[ADDR_WIDTH-1:0]});
    assign has_data = (wr_ptr != commit_ptr);
    assign commit   = out_end && out_good && !drop_frame && has_data;
    assign last_ptr = wr_ptr - 1'b1;

    // At commit the final entry is rewritten with its last flag set
    assign mem_we    = commit || (out_valid && !full && !drop_frame);
    assign mem_waddr = commit ? last_ptr[ADDR_WIDTH-1:0] : wr_ptr[ADDR_WIDTH-1:0];
    assign mem_wdata = commit ? fifo_word_t'({1'b1, last_byte})
                              : fifo_word_t'({1'b0, out_data});

    assign rd_word  = mem[rd_ptr[ADDR_WIDTH-1:0]];
    assign load_out = (rd_ptr != commit_ptr) && (!rx_axis_tvalid || rx_axis_tready);

    always_ff @(posedge logic_clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
        if (out_valid) begin
            last_byte <= out_data;
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr             <= '0;
            commit_ptr         <= '0;
            rd_ptr             <= '0;
            drop_frame         <= 1'b0;
            rx_axis_tvalid     <= 1'b0;
            rx_fifo_overflow   <= 1'b0;
            rx_fifo_good_frame <= 1'b0;
            rx_fifo_bad_frame  <= 1'b0;
        end else begin
            rx_fifo_overflow   <= 1'b0;
            rx_fifo_good_frame <= 1'b0;
            rx_fifo_bad_frame  <= 1'b0;
            if (out_end) begin
                drop_frame <= 1'b0;
                if (commit) begin
                    commit_ptr         <= wr_ptr;
                    rx_fifo_good_frame <= 1'b1;
                end else begin
                    wr_ptr            <= commit_ptr;
                    rx_fifo_bad_frame <= 1'b1;
                    rx_fifo_overflow  <= drop_frame;
                end
            end else if (out_valid && !drop_frame) begin
                // Once a byte misses, the rest of the frame is discarded too
                if (full) begin
                    drop_frame <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end

            // Output register, reloaded when empty or on a transfer
            if (load_out) begin
                rd_ptr         <= rd_ptr + 1'b1;
                rx_axis_tvalid <= 1'b1;
            end else if (rx_axis_tready) begin
                rx_axis_tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (load_out) begin
            rx_axis_tdata <= rd_word[7:0];
            rx_axis_tlast <= rd_word[8];
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the receive MAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module eth_mac_mii_rx_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Veth_mac_mii_rx_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

// File: sim.f
+incdir+include
rtl/mii_pkg.sv
rtl/eth_stream_pkg.sv
rtl/mii_rx_decode.sv
rtl/eth_fcs_check.sv
rtl/rx_frame_fifo.sv
rtl/eth_mac_mii_rx.sv
sim/eth_mac_mii_rx_assert.sv
sim/eth_mac_mii_rx_tb.sv

// File: sim/eth_mac_mii_rx_assert.sv
/* Concurrent checks on the receive MAC ports.
   Bound into every instance of the top level. */
`timescale 1ns/1ps

module eth_mac_mii_rx_assert (
    input logic                      logic_clk,
    input logic                      logic_rst,
    input eth_stream_pkg::eth_byte_t rx_axis_tdata,
    input logic                      rx_axis_tvalid,
    input logic                      rx_axis_tready,
    input logic                      rx_axis_tlast,
    input logic                      rx_error_bad_frame,
    input logic                      rx_error_bad_fcs,
    input logic                      rx_fifo_overflow,
    input logic                      rx_fifo_good_frame,
    input logic                      rx_fifo_bad_frame
);

    // Stalled output must hold
    stall_hold: assert property (@(posedge logic_clk) disable iff (logic_rst)
        rx_axis_tvalid && !rx_axis_tready |=>
        rx_axis_tvalid && $stable(rx_axis_tdata) && $stable(rx_axis_tlast))
        else $error("Stream output changed while tready was low");

    // Only an error cause may share a cycle with the rollback pulse
    pulse_exclusive: assert property (@(posedge logic_clk) disable iff (logic_rst)
        !(rx_fifo_good_frame && (rx_fifo_bad_frame || rx_fifo_overflow ||
                                 rx_error_bad_frame || rx_error_bad_fcs)) &&
        !(rx_error_bad_frame && rx_error_bad_fcs) &&
        !(rx_fifo_overflow && !rx_fifo_bad_frame))
        else $error("Conflicting status pulses in one cycle");

    // Still quiet after the first active edge
    reset_quiet: assert property (@(posedge logic_clk)
        (logic_rst || $fell(logic_rst)) |=> !rx_axis_tvalid)
        else $error("tvalid high during or right after reset");

endmodule

bind eth_mac_mii_rx eth_mac_mii_rx_assert eth_mac_mii_rx_assert_i (.*);

// File: sim/eth_mac_mii_rx_tb.sv
/* Testbench for the MII receive MAC. Sends random frames over MII, compares
   the byte stream with a reference model and counts the status pulses. */
`timescale 1ns/1ps

`include "eth_settings.svh"

module eth_mac_mii_rx_tb;
    import mii_pkg::*;
    import eth_stream_pkg::*;

    localparam int FIFO_DEPTH       = 1 << `ETH_RX_FIFO_ADDR_W;
    localparam int MAX_FRAME_BYTES  = 120;
    localparam int PREAMBLE_NIBBLES = 16;
    localparam int GAP_NIBBLES      = 24;
    localparam int FRAME_COUNT      = 21;
    localparam int DRAIN_CYCLES     = 4 * FIFO_DEPTH + 200;
    localparam int TIMEOUT_CYCLES   = FRAME_COUNT * (2 * 2 * MAX_FRAME_BYTES +
                                      PREAMBLE_NIBBLES + GAP_NIBBLES) + DRAIN_CYCLES;
    localparam int READY_HIGH       = 0;
    localparam int READY_RANDOM     = 1;
    localparam int READY_LOW        = 2;

    logic        logic_clk = 1'b0;
    logic        logic_rst = 1'b1;
    mii_nibble_t mii_rxd;
    logic        mii_rx_dv;
    logic        mii_rx_er;
    eth_byte_t   rx_axis_tdata;
    logic        rx_axis_tvalid;
    logic        rx_axis_tready;
    logic        rx_axis_tlast;
    logic        rx_error_bad_frame;
    logic        rx_error_bad_fcs;
    logic        rx_fifo_overflow;
    logic        rx_fifo_good_frame;
    logic        rx_fifo_bad_frame;

    logic [31:0] lfsr_state;
    int          ready_mode;
    eth_byte_t   frame_buf [0:MAX_FRAME_BYTES+3];
    logic [8:0]  exp_q [$];
    logic [8:0]  exp_word;
    int exp_good = 0;
    int exp_bad_frame = 0;
    int exp_bad_fcs = 0;
    int exp_fifo_bad = 0;
    int exp_overflow = 0;
    int obs_good = 0;
    int obs_bad_frame = 0;
    int obs_bad_fcs = 0;
    int obs_fifo_bad = 0;
    int obs_overflow = 0;
    int data_errors = 0;
    int status_errors = 0;
    int other_errors = 0;
    int cycle_count = 0;
    int post_reset = 0;

    eth_mac_mii_rx eth_mac_mii_rx_i (.*);

    always #10 logic_clk = ~logic_clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // Expected FCS, reflected CRC-32 with final inversion
    function automatic logic [31:0] crc32_ref(input int len);
        logic [31:0] crc;
        int          i;
        int          b;
        crc = 32'hffffffff;
        for (i = 0; i < len; i++) begin
            crc = crc ^ {24'h0, frame_buf[i]};
            for (b = 0; b < 8; b++) begin
                crc = crc[0] ? ((crc >> 1) ^ 32'hedb88320) : (crc >> 1);
            end
        end
        return ~crc;
    endfunction

    task automatic random_bits(input int n, output int value);
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // One clock, then drive just after the edge
    task automatic tick();
        int r;
        @(posedge logic_clk);
        #2;
        case (ready_mode)
            READY_RANDOM: begin
                random_bits(2, r);
                rx_axis_tready = (r != 0);
            end
            READY_LOW: rx_axis_tready = 1'b0;
            default: rx_axis_tready = 1'b1;
        endcase
    endtask

    task automatic drive_nibble(input mii_nibble_t nib, input logic dv, input logic er);
        tick();
        mii_rxd   = nib;
        mii_rx_dv = dv;
        mii_rx_er = er;
    endtask

    task automatic fill_payload(input int len);
        int i;
        int r;
        for (i = 0; i < len; i++) begin
            random_bits(8, r);
            frame_buf[i] = eth_byte_t'(r);
        end
    endtask

    task automatic random_length(output int len);
        int r;
        random_bits(6, r);
        len = `ETH_MIN_FRAME_BYTES - 4 + (r % (MAX_FRAME_BYTES - `ETH_MIN_FRAME_BYTES + 1));
    endtask

    task automatic expect_frame(input int len);
        int i;
        for (i = 0; i < len; i++) begin
            exp_q.push_back({(i == len - 1), frame_buf[i]});
        end
    endtask

    // Preamble, SFD, payload and FCS low nibble first, then the gap
    task automatic send_frame(input int len, input logic corrupt, input int er_at);
        logic [31:0] fcs;
        int          i;
        fcs = crc32_ref(len);
        if (corrupt) begin
            fcs = fcs ^ 32'h00010000;
        end
        for (i = 0; i < 4; i++) begin
            frame_buf[len + i] = fcs[8*i +: 8];
        end
        for (i = 0; i < PREAMBLE_NIBBLES - 1; i++) begin
            drive_nibble(4'h5, 1'b1, 1'b0);
        end
        drive_nibble(4'hd, 1'b1, 1'b0);
        for (i = 0; i < 2 * (len + 4); i++) begin
            drive_nibble(i[0] ? frame_buf[i/2][7:4] : frame_buf[i/2][3:0], 1'b1, (i == er_at));
        end
        for (i = 0; i < GAP_NIBBLES; i++) begin
            drive_nibble(4'h0, 1'b0, 1'b0);
        end
    endtask

    task automatic good_frame(input int len);
        fill_payload(len);
        expect_frame(len);
        exp_good++;
        send_frame(len, 1'b0, -1);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            tick();
        end
        repeat (8) tick();
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        assert (got == expected) else begin
            status_errors++;
            $display("Mismatch at %0t: %s count got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d data, %0d status, %0d other", data_errors, status_errors,
                 other_errors);
        if (data_errors + status_errors + other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // Compare every accepted byte with the head of the queue
    always @(posedge logic_clk) begin
        if (!logic_rst && rx_axis_tvalid && rx_axis_tready) begin
            assert (exp_q.size() > 0) else begin
                data_errors++;
                $display("Unexpected output byte %h at %0t with no frame pending",
                         rx_axis_tdata, $time);
            end
            if (exp_q.size() > 0) begin
                exp_word = exp_q.pop_front();
                assert (rx_axis_tdata == exp_word[7:0]) else begin
                    data_errors++;
                    $display("Mismatch at %0t: rx_axis_tdata got %h expected %h", $time,
                             rx_axis_tdata, exp_word[7:0]);
                end
                assert (rx_axis_tlast == exp_word[8]) else begin
                    data_errors++;
                    $display("Mismatch at %0t: rx_axis_tlast got %b expected %b", $time,
                             rx_axis_tlast, exp_word[8]);
                end
            end
        end
    end

    // Status pulse counts and quiet outputs around reset
    always @(posedge logic_clk) begin
        if (logic_rst) begin
            post_reset = 0;
        end else begin
            if (post_reset < 4) post_reset++;
            if (rx_fifo_good_frame) obs_good++;
            if (rx_error_bad_frame) obs_bad_frame++;
            if (rx_error_bad_fcs) obs_bad_fcs++;
            if (rx_fifo_bad_frame) obs_fifo_bad++;
            if (rx_fifo_overflow) obs_overflow++;
        end
        if (post_reset < 4) begin
            assert (!rx_axis_tvalid && !rx_error_bad_frame && !rx_error_bad_fcs &&
                    !rx_fifo_overflow && !rx_fifo_good_frame && !rx_fifo_bad_frame) else begin
                other_errors++;
                $display("Outputs active at %0t during or just after reset", $time);
            end
        end
    end

    always @(posedge logic_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            other_errors++;
            $display("Timeout after %0d cycles, frames did not drain", cycle_count);
            finish_run();
        end
    end

    initial begin
        int i;
        int r;
        int len;
        int held;
        lfsr_state     = 32'h8b25f059;
        ready_mode     = READY_HIGH;
        mii_rxd        = '0;
        mii_rx_dv      = 1'b0;
        mii_rx_er      = 1'b0;
        rx_axis_tready = 1'b1;

        // Line activity while reset is held
        for (i = 0; i < 4; i++) begin
            tick();
            random_bits(4, r);
            mii_rxd   = mii_nibble_t'(r);
            mii_rx_dv = 1'b1;
        end
        tick();
        logic_rst = 1'b0;
        mii_rx_dv = 1'b0;
        mii_rxd   = '0;
        repeat (8) tick();

        for (i = 0; i < 4; i++) begin
            random_length(len);
            good_frame(len);
        end
        wait_drain();

        // Corrupted FCS between two good frames
        random_length(len);
        good_frame(len);
        random_length(len);
        fill_payload(len);
        exp_bad_fcs++;
        exp_fifo_bad++;
        send_frame(len, 1'b1, -1);
        random_length(len);
        good_frame(len);
        wait_drain();

        // Line error mid-frame, then a runt with a valid FCS
        random_length(len);
        fill_payload(len);
        exp_bad_frame++;
        exp_fifo_bad++;
        send_frame(len, 1'b0, len);
        len = `ETH_MIN_FRAME_BYTES - 24;
        fill_payload(len);
        exp_fifo_bad++;
        send_frame(len, 1'b0, -1);
        random_length(len);
        good_frame(len);
        wait_drain();

        ready_mode = READY_RANDOM;
        for (i = 0; i < 6; i++) begin
            random_length(len);
            good_frame(len);
        end
        wait_drain();

        // Stalled output until the FIFO runs out of room
        ready_mode = READY_LOW;
        held = 0;
        for (i = 0; i < 5; i++) begin
            len = (i == 4) ? 60 : 96;
            fill_payload(len);
            if (held + len <= FIFO_DEPTH) begin
                expect_frame(len);
                exp_good++;
                held += len;
            end else begin
                exp_overflow++;
                exp_fifo_bad++;
            end
            send_frame(len, 1'b0, -1);
        end
        ready_mode = READY_HIGH;
        wait_drain();

        check_count("rx_fifo_good_frame", obs_good, exp_good);
        check_count("rx_error_bad_frame", obs_bad_frame, exp_bad_frame);
        check_count("rx_error_bad_fcs", obs_bad_fcs, exp_bad_fcs);
        check_count("rx_fifo_bad_frame", obs_fifo_bad, exp_fifo_bad);
        check_count("rx_fifo_overflow", obs_overflow, exp_overflow);
        finish_run();
    end

endmodule
